//--- tb.f
+incdir+common
common/vec_pkg.sv
verilog/vec_fifo.sv
sequencer/vec_sequencer.sv
lane/vec_lane.sv
verilog/vec_reduce.sv
verilog/vec_top.sv
verif/vec_sva.sv
verif/vec_tb.sv

//--- Bender.yml
package:
  name: vec_core

export_include_dirs:
  - common

sources:
  - files:
      - common/vec_pkg.sv
      - verilog/vec_fifo.sv
      - sequencer/vec_sequencer.sv
      - lane/vec_lane.sv
      - verilog/vec_reduce.sv
      - verilog/vec_top.sv
  - target: test
    files:
      - verif/vec_sva.sv
      - verif/vec_tb.sv

//--- verif/vec_tb.sv
// Directed testbench for the vector core top level
// A reference model holds all 8 registers of 8 elements
// Every request yields one response
// Write ops answer zero
// VEXT ignores vl and uses scalar mod 8 as the element index

`timescale 1ns/1ps
`default_nettype none

`include "vec_macros.svh"

module vec_tb;

  import vec_pkg::*;

  localparam int CLK_HALF     = 5;
  localparam int NR_REGS      = `VEC_NR_REGS;
  localparam int NR_ELEMS     = `VEC_NR_ELEMS;
  localparam int ELEM_ROUNDS  = 2;
  localparam int TAIL_ROUNDS  = 4;
  localparam int BP_MAX       = 8;
  localparam int STALL_CYCLES = 20;
  localparam int NUM_REQS     = 1 + NR_REGS * (NR_ELEMS + 2)
                              + ELEM_ROUNDS * 3 * (NR_ELEMS + 2)
                              + TAIL_ROUNDS * (NR_ELEMS + 2) + BP_MAX;
  localparam int WATCHDOG_CYCLES = NUM_REQS * 40;

  logic    clk_i;
  logic    rst_n_i;
  logic    req_valid_i;
  logic    req_ready_o;
  vec_op_e req_op_i;
  vreg_t   req_vs1_i;
  vreg_t   req_vs2_i;
  vreg_t   req_vd_i;
  elem_t   req_scalar_i;
  vl_t     req_vl_i;
  logic    resp_valid_o;
  logic    resp_ready_i;
  elem_t   resp_data_o;
  logic    idle_o;

  // Reference register file, global element order
  elem_t       model [NR_REGS][NR_ELEMS];
  logic [31:0] rng_q;
  string       cur_test;
  int          test_errs;
  int          err_count;
  int          check_count;
  int          test_count;

  vec_top vec_top_i (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .req_op_i     (req_op_i    ),
    .req_vs1_i    (req_vs1_i   ),
    .req_vs2_i    (req_vs2_i   ),
    .req_vd_i     (req_vd_i    ),
    .req_scalar_i (req_scalar_i),
    .req_vl_i     (req_vl_i    ),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_data_o  (resp_data_o ),
    .idle_o       (idle_o      )
  );

  initial clk_i = 1'b0;
  always #CLK_HALF clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  task automatic check_val(input string what, input elem_t exp, input elem_t act);
    check_count++;
    if (exp !== act) begin
      $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
      err_count++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", cur_test, msg);
    test_errs++;
    err_count++;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    test_count++;
    $display("%s finished with %0d errors", cur_test, test_errs);
  endtask

  ////////////////////////////////////////
  // Handshake drivers
  ////////////////////////////////////////

  task automatic send_req(input vec_op_e op, input vreg_t vs1, input vreg_t vs2,
                          input vreg_t vd, input elem_t scalar, input vl_t vl);
    @(posedge clk_i);
    req_valid_i  <= 1'b1;
    req_op_i     <= op;
    req_vs1_i    <= vs1;
    req_vs2_i    <= vs2;
    req_vd_i     <= vd;
    req_scalar_i <= scalar;
    req_vl_i     <= vl;
    // Ready only moves on rising edges
    @(negedge clk_i);
    while (!req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic recv_resp(output elem_t data);
    @(negedge clk_i);
    while (!resp_valid_o) @(negedge clk_i);
    data = resp_data_o;
    @(posedge clk_i);
    resp_ready_i <= 1'b1;
    @(posedge clk_i);
    resp_ready_i <= 1'b0;
  endtask

  // Applies one instruction to the model and gives the expected response
  task automatic model_apply(input vec_op_e op, input vreg_t vs1, input vreg_t vs2,
                             input vreg_t vd, input elem_t scalar, input vl_t vl,
                             output elem_t exp);
    exp = '0;
    case (op)
      VREDSUM: begin
        exp = scalar;
        for (int i = 0; i < NR_ELEMS; i++) begin
          if (i < vl) exp = exp + model[vs1][i];
        end
      end
      VEXT: exp = model[vs1][scalar % NR_ELEMS];
      default: begin
        for (int i = 0; i < NR_ELEMS; i++) begin
          if (i < vl) begin
            case (op)
              VBCAST: model[vd][i] = scalar;
              VADD:   model[vd][i] = model[vs1][i] + model[vs2][i];
              VXOR:   model[vd][i] = model[vs1][i] ^ model[vs2][i];
              VADDS:  model[vd][i] = model[vs1][i] + scalar;
              default: ;
            endcase
          end
        end
      end
    endcase
  endtask

  task automatic run_op(input vec_op_e op, input vreg_t vs1, input vreg_t vs2,
                        input vreg_t vd, input elem_t scalar, input vl_t vl);
    elem_t exp;
    elem_t act;
    model_apply(op, vs1, vs2, vd, scalar, vl, exp);
    send_req(op, vs1, vs2, vd, scalar, vl);
    recv_resp(act);
    check_val($sformatf("%s vs1=%0d vd=%0d scalar=%h vl=%0d", op.name(), vs1, vd,
                        scalar, vl), exp, act);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic reset_state();
    begin_test("reset_state");
    @(negedge clk_i);
    check_val("req_ready_o", 1, req_ready_o);
    check_val("idle_o", 1, idle_o);
    check_val("resp_valid_o", 0, resp_valid_o);
    run_op(VEXT, vreg_t'(next_rand()), '0, '0, next_rand(), vl_t'(NR_ELEMS));
    end_test();
  endtask

  task automatic bcast_extract();
    begin_test("bcast_ext");
    // Full broadcast, then a shorter one so each register has a step
    for (int r = 0; r < NR_REGS; r++) begin
      run_op(VBCAST, '0, '0, vreg_t'(r), next_rand(), vl_t'(NR_ELEMS));
      run_op(VBCAST, '0, '0, vreg_t'(r), next_rand(), vl_t'(r));
    end
    // Random upper index bits must be ignored
    for (int r = 0; r < NR_REGS; r++) begin
      for (int e = 0; e < NR_ELEMS; e++) begin
        run_op(VEXT, vreg_t'(r), '0, '0, elem_t'(e) + (next_rand() & 32'hFFFF_FFF8),
               vl_t'(NR_ELEMS));
      end
    end
    end_test();
  endtask

  task automatic elementwise_ops();
    vec_op_e op;
    vreg_t   vd;
    begin_test("elem_ops");
    for (int rnd = 0; rnd < ELEM_ROUNDS; rnd++) begin
      for (int k = 0; k < 3; k++) begin
        op = (k == 0) ? VADD : (k == 1) ? VXOR : VADDS;
        vd = vreg_t'(next_rand());
        run_op(op, vreg_t'(next_rand()), vreg_t'(next_rand()), vd, next_rand(),
               vl_t'(NR_ELEMS));
        for (int e = 0; e < NR_ELEMS; e++) begin
          run_op(VEXT, vd, '0, '0, elem_t'(e), vl_t'(NR_ELEMS));
        end
        run_op(VREDSUM, vd, '0, '0, next_rand(), vl_t'(NR_ELEMS));
      end
    end
    end_test();
  endtask

  task automatic tail_undisturbed();
    vec_op_e op;
    vreg_t   vd;
    vl_t     vl;
    begin_test("tail_undisturbed");
    for (int rnd = 0; rnd < TAIL_ROUNDS; rnd++) begin
      op = vec_op_e'(next_rand() % 4);
      vd = vreg_t'(next_rand());
      vl = vl_t'(next_rand() % NR_ELEMS);
      run_op(op, vreg_t'(next_rand()), vreg_t'(next_rand()), vd, next_rand(), vl);
      for (int e = 0; e < NR_ELEMS; e++) begin
        run_op(VEXT, vd, '0, '0, elem_t'(e), vl_t'(NR_ELEMS));
      end
      run_op(VREDSUM, vd, '0, '0, next_rand(), vl);
    end
    end_test();
  endtask

  task automatic backpressure_order();
    elem_t   exp_q [$];
    elem_t   exp;
    elem_t   act;
    vec_op_e op;
    vreg_t   vs1;
    elem_t   scalar;
    int      pushed;
    int      waited;
    logic    full;
    begin_test("backpressure");
    pushed = 0;
    full   = 1'b0;
    while (!full && pushed < BP_MAX) begin
      // Wait for room in the request queue
      waited = 0;
      @(negedge clk_i);
      while (!req_ready_o && waited < STALL_CYCLES) begin
        @(negedge clk_i);
        waited++;
      end
      if (!req_ready_o) begin
        full = 1'b1;
      end else begin
        op     = (pushed % 3 == 0) ? VADDS : (pushed % 3 == 1) ? VREDSUM : VEXT;
        vs1    = vreg_t'(next_rand());
        scalar = next_rand();
        model_apply(op, vs1, vs1, vs1, scalar, vl_t'(NR_ELEMS), exp);
        exp_q.push_back(exp);
        send_req(op, vs1, vs1, vs1, scalar, vl_t'(NR_ELEMS));
        pushed++;
      end
    end
    if (!full) report_failure("request ready never dropped while responses were held");
    check_val("accepted count", 2 * `VEC_FIFO_DEPTH + 1, pushed);
    while (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      recv_resp(act);
      check_val("in-order response", exp, act);
    end
    waited = 0;
    @(negedge clk_i);
    while (!idle_o && waited < STALL_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    check_val("idle_o", 1, idle_o);
    end_test();
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    rst_n_i      = 1'b1;
    req_valid_i  = 1'b0;
    req_op_i     = VBCAST;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    req_vd_i     = '0;
    req_scalar_i = '0;
    req_vl_i     = '0;
    resp_ready_i = 1'b0;
    rng_q        = 32'd48595;
    err_count    = 0;
    check_count  = 0;
    test_count   = 0;
    for (int r = 0; r < NR_REGS; r++) begin
      for (int e = 0; e < NR_ELEMS; e++) begin
        model[r][e] = '0;
      end
    end
    #1;
    rst_n_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    reset_state();
    bcast_extract();
    elementwise_ops();
    tail_undisturbed();
    backpressure_order();
    if (vec_top_i.i_vec_sva.assert_fails != 0) begin
      $display("Handshake assertions failed %0d times", vec_top_i.i_vec_sva.assert_fails);
      err_count += vec_top_i.i_vec_sva.assert_fails;
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule : vec_tb

`default_nettype wire

//--- verif/vec_sva.sv
// Handshake assertions for the vector core top level
// Bound into every vec_top instance
// Request checks assume the driver holds valid until accepted

`timescale 1ns/1ps
`default_nettype none

module vec_sva (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             req_valid_i,
  input logic             req_ready_o,
  input vec_pkg::vec_op_e req_op_i,
  input vec_pkg::vreg_t   req_vs1_i,
  input vec_pkg::vreg_t   req_vs2_i,
  input vec_pkg::vreg_t   req_vd_i,
  input vec_pkg::elem_t   req_scalar_i,
  input vec_pkg::vl_t     req_vl_i,
  input logic             resp_valid_o,
  input logic             resp_ready_i,
  input vec_pkg::elem_t   resp_data_o
);

  // Number of failed assertions
  int unsigned assert_fails;

  initial assert_fails = 0;

  // Stalled request keeps valid and payload
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_ready_o |=> req_valid_i &&
      $stable({req_op_i, req_vs1_i, req_vs2_i, req_vd_i, req_scalar_i, req_vl_i}))
    else begin
      $error("request payload changed while stalled");
      assert_fails++;
    end

  // Stalled response keeps valid and data
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o))
    else begin
      $error("response dropped or changed while stalled");
      assert_fails++;
    end

  a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !resp_valid_o)
    else begin
      $error("response valid high during reset");
      assert_fails++;
    end

endmodule : vec_sva

bind vec_top vec_sva i_vec_sva (
  .clk_i        (clk_i       ),
  .rst_n_i      (rst_n_i     ),
  .req_valid_i  (req_valid_i ),
  .req_ready_o  (req_ready_o ),
  .req_op_i     (req_op_i    ),
  .req_vs1_i    (req_vs1_i   ),
  .req_vs2_i    (req_vs2_i   ),
  .req_vd_i     (req_vd_i    ),
  .req_scalar_i (req_scalar_i),
  .req_vl_i     (req_vl_i    ),
  .resp_valid_o (resp_valid_o),
  .resp_ready_i (resp_ready_i),
  .resp_data_o  (resp_data_o )
);

`default_nettype wire

//--- verilog/vec_top.sv
// Vector core top: request queue, sequencer, lanes, reducer, response queue
// Instructions run strictly one at a time
// Response latency is at least 8 cycles and grows with queue occupancy
// Requests and responses leave in the same order

`timescale 1ns/1ps
`default_nettype none

`include "vec_macros.svh"

module vec_top (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  vec_pkg::vec_op_e req_op_i,
  input  vec_pkg::vreg_t   req_vs1_i,
  input  vec_pkg::vreg_t   req_vs2_i,
  input  vec_pkg::vreg_t   req_vd_i,
  input  vec_pkg::elem_t   req_scalar_i,
  input  vec_pkg::vl_t     req_vl_i,
  output logic             resp_valid_o,
  input  logic             resp_ready_i,
  output vec_pkg::elem_t   resp_data_o,
  output logic             idle_o
);

  import vec_pkg::*;

  vec_req_t                 req_in;
  vec_req_t                 req_q_data;
  logic                     req_q_valid;
  logic                     req_q_ready;
  logic                     req_empty;
  logic                     start;
  vec_op_e                  op;
  vreg_t                    vs1;
  vreg_t                    vs2;
  vreg_t                    vd;
  elem_t                    scalar;
  vl_t                      vl;
  logic                     seq_busy;
  logic [`VEC_NR_LANES-1:0] lane_done;
  elem_t [`VEC_NR_LANES-1:0] lane_sum;
  vec_resp_t                red_data;
  logic                     red_valid;
  logic                     red_ready;
  logic                     result_done;
  vec_resp_t                resp_out;
  logic                     resp_empty;

  assign req_in = '{op: req_op_i, vs1: req_vs1_i, vs2: req_vs2_i, vd: req_vd_i,
                    scalar: req_scalar_i, vl: req_vl_i};

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  vec_fifo #(
    .T     (vec_req_t      ),
    .DEPTH (`VEC_FIFO_DEPTH)
  ) i_req_fifo (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_data_i   (req_in     ),
    .out_valid_o (req_q_valid),
    .out_ready_i (req_q_ready),
    .out_data_o  (req_q_data ),
    .empty_o     (req_empty  )
  );

  vec_sequencer i_sequencer (
    .clk_i         (clk_i      ),
    .rst_n_i       (rst_n_i    ),
    .req_valid_i   (req_q_valid),
    .req_ready_o   (req_q_ready),
    .req_i         (req_q_data ),
    .start_o       (start      ),
    .op_o          (op         ),
    .vs1_o         (vs1        ),
    .vs2_o         (vs2        ),
    .vd_o          (vd         ),
    .scalar_o      (scalar     ),
    .vl_o          (vl         ),
    .result_done_i (result_done),
    .busy_o        (seq_busy   )
  );

  ////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (l)
    ) i_lane (
      .clk_i       (clk_i       ),
      .rst_n_i     (rst_n_i     ),
      .start_i     (start       ),
      .op_i        (op          ),
      .vs1_i       (vs1         ),
      .vs2_i       (vs2         ),
      .vd_i        (vd          ),
      .scalar_i    (scalar      ),
      .vl_i        (vl          ),
      .lane_done_o (lane_done[l]),
      .lane_sum_o  (lane_sum[l] )
    );
  end : gen_lanes

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  vec_reduce i_reduce (
    .clk_i         (clk_i      ),
    .rst_n_i       (rst_n_i    ),
    .lane_done_i   (lane_done  ),
    .lane_sum_i    (lane_sum   ),
    .op_i          (op         ),
    .scalar_i      (scalar     ),
    .out_ready_i   (red_ready  ),
    .out_valid_o   (red_valid  ),
    .out_data_o    (red_data   ),
    .result_done_o (result_done)
  );

  vec_fifo #(
    .T     (vec_resp_t     ),
    .DEPTH (`VEC_FIFO_DEPTH)
  ) i_resp_fifo (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .in_valid_i  (red_valid   ),
    .in_ready_o  (red_ready   ),
    .in_data_i   (red_data    ),
    .out_valid_o (resp_valid_o),
    .out_ready_i (resp_ready_i),
    .out_data_o  (resp_out    ),
    .empty_o     (resp_empty  )
  );

  assign resp_data_o = resp_out.data;
  assign idle_o      = req_empty & resp_empty & !seq_busy;

endmodule : vec_top

`default_nettype wire

//--- verilog/vec_reduce.sv
// Combines the lane partial sums into one scalar response
// Lane dones may arrive in different cycles, each one is remembered
// Seed is added for VREDSUM only
// Result is held until the response queue takes it

`timescale 1ns/1ps
`default_nettype none

`include "vec_macros.svh"

module vec_reduce (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic               [`VEC_NR_LANES-1:0] lane_done_i,
  input  vec_pkg::elem_t     [`VEC_NR_LANES-1:0] lane_sum_i,
  input  vec_pkg::vec_op_e                       op_i,
  input  vec_pkg::elem_t                         scalar_i,
  input  logic                                   out_ready_i,
  output logic                                   out_valid_o,
  output vec_pkg::vec_resp_t                     out_data_o,
  output logic                                   result_done_o
);

  import vec_pkg::*;

  logic [`VEC_NR_LANES-1:0] seen_q;
  logic [`VEC_NR_LANES-1:0] seen_d;
  logic                     capture;
  logic                     valid_q;
  vec_resp_t                data_q;
  elem_t                    lane_total;

  assign seen_d  = seen_q | lane_done_i;
  assign capture = &seen_d;

  always_comb begin
    lane_total = '0;
    for (int l = 0; l < `VEC_NR_LANES; l++) begin
      lane_total = lane_total + lane_sum_i[l];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seen_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      seen_q <= capture ? '0 : seen_d;
      if (capture) valid_q <= 1'b1;
      else if (out_ready_i) valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) data_q.data <= lane_total + ((op_i == VREDSUM) ? scalar_i : '0);
  end

  assign out_valid_o   = valid_q;
  assign out_data_o    = data_q;
  // Acceptance by the response queue ends the instruction
  assign result_done_o = valid_q & out_ready_i;

endmodule : vec_reduce

`default_nettype wire

//--- lane/vec_lane.sv
// One lane: its slice of every vector register plus element loop
// Global element index is local index * lanes + LANE_ID
// Index 0 is handled in the start cycle, done follows 4 cycles later
// VEXT reads vs1 and ignores vl, the index is scalar mod element count
// Register file resets to zero

`timescale 1ns/1ps
`default_nettype none

`include "vec_macros.svh"

module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             start_i,
  input  vec_pkg::vec_op_e op_i,
  input  vec_pkg::vreg_t   vs1_i,
  input  vec_pkg::vreg_t   vs2_i,
  input  vec_pkg::vreg_t   vd_i,
  input  vec_pkg::elem_t   scalar_i,
  input  vec_pkg::vl_t     vl_i,
  output logic             lane_done_o,
  output vec_pkg::elem_t   lane_sum_o
);

  import vec_pkg::*;

  localparam int unsigned      IDX_W    = $clog2(`VEC_ELEMS_PER_LANE);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`VEC_ELEMS_PER_LANE - 1);

  elem_t            vrf_q [`VEC_NR_REGS][`VEC_ELEMS_PER_LANE];
  logic [IDX_W-1:0] idx_q;
  logic             busy_q;
  logic             done_q;
  elem_t            sum_q;

  logic  step;
  vl_t   gidx;
  vl_t   ext_idx;
  logic  active;
  elem_t op_a;
  elem_t op_b;
  logic  wr_en;
  elem_t wr_data;
  elem_t sum_base;
  elem_t sum_d;

  if (LANE_ID >= `VEC_NR_LANES) begin : gen_bad_id
    $error("vec_lane: LANE_ID must be below the lane count");
  end

  ////////////////////////////////////////
  // Element step
  ////////////////////////////////////////

  // idx_q rests at zero between instructions
  assign step    = start_i | busy_q;
  assign gidx    = vl_t'(idx_q * `VEC_NR_LANES + LANE_ID);
  assign ext_idx = vl_t'(scalar_i % `VEC_NR_ELEMS);
  assign active  = (gidx < vl_i);
  assign op_a    = vrf_q[vs1_i][idx_q];
  assign op_b    = vrf_q[vs2_i][idx_q];

  always_comb begin
    wr_en    = 1'b0;
    wr_data  = op_a + op_b;
    sum_base = start_i ? '0 : sum_q;
    sum_d    = sum_base;
    case (op_i)
      VBCAST: begin
        wr_en   = active;
        wr_data = scalar_i;
      end
      VADD: wr_en = active;
      VXOR: begin
        wr_en   = active;
        wr_data = op_a ^ op_b;
      end
      VADDS: begin
        wr_en   = active;
        wr_data = op_a + scalar_i;
      end
      VREDSUM: if (active) sum_d = sum_base + op_a;
      // Only the lane owning the element reports it, the other stays zero
      VEXT: if (gidx == ext_idx) sum_d = op_a;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_q  <= '0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
      sum_q  <= '0;
    end else begin
      done_q <= step && (idx_q == LAST_IDX);
      if (step) begin
        idx_q  <= (idx_q == LAST_IDX) ? '0 : idx_q + 1'b1;
        busy_q <= (idx_q != LAST_IDX);
        sum_q  <= sum_d;
      end
    end
  end

  ////////////////////////////////////////
  // Register file slice
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < `VEC_NR_REGS; r++) begin
        for (int e = 0; e < `VEC_ELEMS_PER_LANE; e++) begin
          vrf_q[r][e] <= '0;
        end
      end
    end else if (step && wr_en) begin
      vrf_q[vd_i][idx_q] <= wr_data;
    end
  end

  assign lane_done_o = done_q;
  assign lane_sum_o  = sum_q;

endmodule : vec_lane

`default_nettype wire

//--- sequencer/vec_sequencer.sv
// Issues one vector instruction at a time to all lanes
// Start is a one-cycle pulse in the cycle after the pop
// Instruction fields hold steady until the next pop
// A new request is taken only after result_done_i

`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // From the request queue
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  vec_pkg::vec_req_t req_i,
  // To the lanes and the reducer
  output logic              start_o,
  output vec_pkg::vec_op_e  op_o,
  output vec_pkg::vreg_t    vs1_o,
  output vec_pkg::vreg_t    vs2_o,
  output vec_pkg::vreg_t    vd_o,
  output vec_pkg::elem_t    scalar_o,
  output vec_pkg::vl_t      vl_o,
  // Completion from the reducer
  input  logic              result_done_i,
  output logic              busy_o
);

  import vec_pkg::*;

  vec_req_t req_q;
  logic     busy_q;
  logic     start_q;
  logic     pop;

  // Only one instruction in flight
  assign req_ready_o = !busy_q;
  assign pop         = req_valid_i & !busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= pop;
      if (pop) begin
        busy_q <= 1'b1;
      end else if (result_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Held instruction fields
  always_ff @(posedge clk_i) begin
    if (pop) req_q <= req_i;
  end

  assign start_o  = start_q;
  assign op_o     = req_q.op;
  assign vs1_o    = req_q.vs1;
  assign vs2_o    = req_q.vs2;
  assign vd_o     = req_q.vd;
  assign scalar_o = req_q.scalar;
  assign vl_o     = req_q.vl;
  assign busy_o   = busy_q;

endmodule : vec_sequencer

`default_nettype wire

//--- verilog/vec_fifo.sv
// Valid/ready queue, payload type given by T
// Push data shows at the output one cycle later, no bypass
// Ready is low when full, even if a pop happens in that cycle
// Storage has no reset, only pointers and count do

`timescale 1ns/1ps
`default_nettype none

module vec_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign empty_o     = (count_q == '0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      // Count only moves when one side transfers alone
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

endmodule : vec_fifo

`default_nettype wire

//--- common/vec_pkg.sv
// Opcodes, element types and the request/response records
// Widths come from the size macros
// A request carries one complete vector instruction

`default_nettype none

`include "vec_macros.svh"

package vec_pkg;

  // Kept subset of the vector instruction set
  typedef enum logic [2:0] {
    VBCAST  = 3'd0,
    VADD    = 3'd1,
    VXOR    = 3'd2,
    VADDS   = 3'd3,
    VREDSUM = 3'd4,
    VEXT    = 3'd5
  } vec_op_e;

  typedef logic [`VEC_ELEN-1:0]  elem_t;
  typedef logic [`VEC_VL_W-1:0]  vl_t;
  typedef logic [`VEC_REG_W-1:0] vreg_t;

  ////////////////////////////////////////
  // Request and response records
  ////////////////////////////////////////

  typedef struct packed {
    vec_op_e op;
    vreg_t   vs1;
    vreg_t   vs2;
    vreg_t   vd;
    // Broadcast value, add operand, reduction seed or element index
    elem_t   scalar;
    vl_t     vl;
  } vec_req_t;

  typedef struct packed {
    elem_t data;
  } vec_resp_t;

endpackage : vec_pkg

`default_nettype wire

//--- common/vec_macros.svh
// Size definitions shared by the RTL and the testbench
// Lane count and elements per lane must be powers of two
// VEC_NR_ELEMS is derived and must not be set on its own
// Add the common folder to the include path

`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Lane organisation
`define VEC_NR_LANES       2
`define VEC_ELEMS_PER_LANE 4
`define VEC_NR_ELEMS       (`VEC_NR_LANES * `VEC_ELEMS_PER_LANE)

// Register file
`define VEC_NR_REGS        8
`define VEC_ELEN           32

// Field widths, vl must hold 0 to VEC_NR_ELEMS
`define VEC_VL_W           4
`define VEC_REG_W          3

// Request and response queues
`define VEC_FIFO_DEPTH     2

`endif
